// ==== vlog.f ====
src/cache_pkg.sv
src/way_array.sv
src/cache_meta.sv
src/cache_ctrl_fsm.sv
src/cache_datapath.sv
src/blocking_cache.sv
dv/mem_model.sv
dv/tb_blocking_cache.sv

// ==== Bender.yml ====
package:
  name: blocking_cache

sources:
  - src/cache_pkg.sv
  - src/way_array.sv
  - src/cache_meta.sv
  - src/cache_ctrl_fsm.sv
  - src/cache_datapath.sv
  - src/blocking_cache.sv
  - target: simulation
    files:
      - dv/mem_model.sv
      - dv/tb_blocking_cache.sv

// ==== dv/tb_blocking_cache.sv ====
//--------------------------------------------------------------------------
// Blocking cache testbench
// Directed and random traffic checked against a word-level reference model
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_blocking_cache
  import cache_pkg::*;
();

  localparam int          reset_cycles = 10;
  localparam int          random_txns  = 60;
  localparam int          num_txns     = 12 + random_txns;
  localparam int          max_cycles   = reset_cycles + 40 * num_txns;
  localparam logic [31:0] lfsr_seed    = 32'hda43;
  localparam logic [31:0] lfsr_taps    = 32'h8020_0003;

  logic        clk;
  logic        reset;
  cache_req_t  cache_req;
  logic        cache_req_val;
  logic        cache_req_rdy;
  cache_resp_t cache_resp;
  logic        cache_resp_val;
  logic        cache_resp_rdy;
  mem_req_t    mem_req;
  logic        mem_req_val;
  logic        mem_req_rdy;
  mem_resp_t   mem_resp;
  logic        mem_resp_val;
  logic        mem_resp_rdy;
  logic        mem_stall;

  // Reference model of contents and of the 2-way LRU per set
  word_t ref_mem [logic [addr_w-1:0]];
  tag_t  model_tag   [num_sets][2];
  logic  model_valid [num_sets][2];
  logic  model_dirty [num_sets][2];
  logic  model_lru   [num_sets];

  string             test_name;
  logic [31:0]       lfsr;
  logic              stall_on;
  logic [addr_w-1:0] exp_refill_addr;
  req_type_e         exp_op;
  logic              exp_hit;
  word_t             exp_data;
  logic              exp_fast;       // Hit or init without memory traffic
  int                exp_evicts;
  logic [addr_w-1:0] exp_evict_addr;
  line_t             exp_evict_line;

  int   cycle_count  = 0;
  logic reset_seen   = 1'b0;
  logic busy         = 1'b0;
  logic resp_first   = 1'b0;
  int   since_accept = 0;
  int   evicts       = 0;
  int   refills      = 0;

  blocking_cache blocking_cache_inst (
    .clk            (clk),
    .reset          (reset),
    .cache_req      (cache_req),
    .cache_req_val  (cache_req_val),
    .cache_req_rdy  (cache_req_rdy),
    .cache_resp     (cache_resp),
    .cache_resp_val (cache_resp_val),
    .cache_resp_rdy (cache_resp_rdy),
    .mem_req        (mem_req),
    .mem_req_val    (mem_req_val),
    .mem_req_rdy    (mem_req_rdy),
    .mem_resp       (mem_resp),
    .mem_resp_val   (mem_resp_val),
    .mem_resp_rdy   (mem_resp_rdy)
  );

  mem_model mem (
    .clk          (clk),
    .reset        (reset),
    .stall        (mem_stall),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  //--------------------------------------------------------------------------
  // Failure reporting and helpers
  //--------------------------------------------------------------------------

  task automatic stop_on_failure();
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic report_mismatch(string what, logic [127:0] expected, logic [127:0] actual);
    $display("Error in %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    stop_on_failure();
  endtask

  task automatic report_problem(string what);
    $display("Failure in %s: %s", test_name, what);
    stop_on_failure();
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[i] = lfsr[0];
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? lfsr_taps : 32'h0);
    end
    return r;
  endfunction

  function automatic word_t ref_word(logic [addr_w-1:0] addr);
    if (ref_mem.exists(addr)) begin
      return ref_mem[addr];
    end
    return addr ^ 32'h5a5a_0000;   // Memory fill rule
  endfunction

  function automatic logic [addr_w-1:0] make_addr(tag_t tag, index_t set, logic [1:0] word);
    return {tag, set, word, 2'b00};
  endfunction

  // Sets the expected response and updates the reference model
  task automatic predict(req_type_e op, logic [addr_w-1:0] addr, word_t data);
    index_t            set;
    tag_t              tag;
    logic              way;
    logic [addr_w-1:0] line_addr;
    set = addr[offset_w +: index_w];
    tag = addr[addr_w-1 -: tag_w];
    exp_hit = (model_valid[set][0] && model_tag[set][0] == tag) ||
              (model_valid[set][1] && model_tag[set][1] == tag);
    way = model_valid[set][1] && model_tag[set][1] == tag;
    exp_op          = op;
    exp_fast        = exp_hit || op == req_init;
    exp_evicts      = 0;
    exp_refill_addr = {addr[addr_w-1:offset_w], 4'b0000};
    if (op == req_init) begin
      way = 1'b0;                  // Init always installs in way 0
      model_tag[set][0]   = tag;
      model_valid[set][0] = 1'b1;
    end else if (!exp_hit) begin
      way = model_lru[set];
      if (model_valid[set][way] && model_dirty[set][way]) begin
        exp_evicts     = 1;
        line_addr      = {model_tag[set][way], set, 4'b0000};
        exp_evict_addr = line_addr;
        for (int i = 0; i < words_per_line; i++) begin
          exp_evict_line[i*word_w +: word_w] = ref_word(line_addr + addr_w'(4 * i));
        end
      end
      model_tag[set][way]   = tag;
      model_valid[set][way] = 1'b1;
      model_dirty[set][way] = 1'b0;
    end
    if (op != req_read) begin
      model_dirty[set][way] = 1'b1;
      ref_mem[addr] = data;
    end
    model_lru[set] = ~way;
    exp_data = (op == req_read) ? ref_word(addr) : '0;
  endtask

  task automatic drive_stalls();
    logic [31:0] bits;
    if (stall_on) begin
      bits           = take_bits(2);
      cache_resp_rdy = bits[0];
      mem_stall      = bits[1];
    end else begin
      cache_resp_rdy = 1'b1;
      mem_stall      = 1'b0;
    end
  endtask

  // One request from hand-off to accepted response
  task automatic do_req(req_type_e op, logic [addr_w-1:0] addr, word_t data);
    logic done;
    predict(op, addr, data);
    cache_req.op   = op;
    cache_req.addr = addr;
    cache_req.data = data;
    cache_req_val  = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = cache_req_val && cache_req_rdy;
      #2;
      drive_stalls();
    end
    cache_req_val = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = cache_resp_val && cache_resp_rdy;
      #2;
      drive_stalls();
    end
  endtask

  //--------------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------------

  // Payloads hold while the receiver stalls
  assert property (@(posedge clk) disable iff (reset)
    cache_resp_val && !cache_resp_rdy |=> cache_resp_val && $stable(cache_resp))
    else report_problem("cache response changed while stalled");

  assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req))
    else report_problem("memory request changed while stalled");

  always @(posedge clk) begin : monitor
    if (reset_seen) begin
      assert (cache_req_rdy && !cache_resp_val && !mem_req_val && !mem_resp_rdy)
        else report_problem("handshake outputs not idle during or right after reset");
    end
    reset_seen = reset;
    if (!reset) begin
      if (cache_req_val && cache_req_rdy) begin
        busy         = 1'b1;
        resp_first   = 1'b1;
        since_accept = 0;
        evicts       = 0;
        refills      = 0;
      end else begin
        since_accept++;
      end
      if (busy && resp_first && cache_resp_val) begin
        resp_first = 1'b0;
        if (exp_fast) begin
          assert (since_accept == 3)
            else report_mismatch("response latency", 128'd3, 128'(since_accept));
        end else begin
          assert (since_accept > 3)
            else report_problem("miss answered as fast as a hit");
        end
      end
      if (mem_req_val) begin
        assert (!exp_fast) else report_problem("memory request during a hit or init");
      end
      // A write-back is due before the refill
      if (mem_req_val && mem_req_rdy) begin
        if (evicts < exp_evicts) begin
          evicts++;
          assert (mem_req.op == mem_write)
            else report_mismatch("evict op", 128'(mem_write), 128'(mem_req.op));
          assert (mem_req.addr == exp_evict_addr)
            else report_mismatch("evict address", exp_evict_addr, mem_req.addr);
          assert (mem_req.data == exp_evict_line)
            else report_mismatch("evict line", exp_evict_line, mem_req.data);
        end else begin
          refills++;
          assert (mem_req.op == mem_read)
            else report_mismatch("refill op", 128'(mem_read), 128'(mem_req.op));
          assert (mem_req.addr == exp_refill_addr)
            else report_mismatch("refill address", exp_refill_addr, mem_req.addr);
        end
      end
      if (busy && cache_resp_val && cache_resp_rdy) begin
        busy = 1'b0;
        assert (cache_resp.op == exp_op)
          else report_mismatch("response type", 128'(exp_op), 128'(cache_resp.op));
        assert (cache_resp.hit == exp_hit)
          else report_mismatch("hit flag", 128'(exp_hit), 128'(cache_resp.hit));
        assert (cache_resp.data == exp_data)
          else report_mismatch("response data", exp_data, cache_resp.data);
        assert (evicts == exp_evicts)
          else report_mismatch("write-back count", 128'(exp_evicts), 128'(evicts));
        assert (refills == (exp_fast ? 0 : 1))
          else report_mismatch("refill count", 128'(!exp_fast), 128'(refills));
      end
    end
  end

  // Run limit from the transaction count
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      report_problem($sformatf("timeout after %0d cycles", cycle_count));
    end
  end

  //--------------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------------

  initial begin : stimulus
    logic [31:0] bits;
    word_t       data;
    test_name      = "reset";
    lfsr           = lfsr_seed;
    stall_on       = 1'b0;
    reset          = 1'b1;
    cache_req      = '0;
    cache_req_val  = 1'b0;
    cache_resp_rdy = 1'b1;
    mem_stall      = 1'b0;
    for (int s = 0; s < num_sets; s++) begin
      model_lru[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        model_valid[s][w] = 1'b0;
        model_dirty[s][w] = 1'b0;
        model_tag[s][w]   = '0;
      end
    end
    repeat (reset_cycles) @(posedge clk);
    #2;
    reset = 1'b0;

    // Set 7 is kept for init only
    test_name = "init_read";
    do_req(req_init, make_addr(25'h100, 3'd7, 2'd2), 32'hc0de_0001);
    do_req(req_read, make_addr(25'h100, 3'd7, 2'd2), '0);

    test_name = "read_miss";
    do_req(req_read, make_addr(25'h21, 3'd1, 2'd3), '0);

    test_name = "write_read";
    do_req(req_write, make_addr(25'h21, 3'd1, 2'd1), 32'h1111_2222);  // Hit
    do_req(req_write, make_addr(25'h33, 3'd2, 2'd0), 32'h3333_4444);  // Miss
    do_req(req_read, make_addr(25'h21, 3'd1, 2'd1), '0);
    do_req(req_read, make_addr(25'h33, 3'd2, 2'd0), '0);
    do_req(req_read, make_addr(25'h33, 3'd2, 2'd2), '0);

    // Third tag in set 3 pushes out a dirty line
    test_name = "dirty_evict";
    for (int i = 0; i < 3; i++) begin
      do_req(req_write, make_addr(tag_t'(32'h40 + i), 3'd3, 2'd0), 32'hd000_0000 + i);
    end
    do_req(req_read, make_addr(25'h40, 3'd3, 2'd0), '0);

    test_name = "backpressure";
    stall_on  = 1'b1;
    repeat (random_txns) begin
      bits = take_bits(7);
      data = take_bits(32);
      do_req(bits[0] ? req_write : req_read,
             make_addr({20'h0, 3'b101, bits[2:1]}, {1'b0, bits[4:3]}, bits[6:5]),
             data);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== dv/mem_model.sv ====
//--------------------------------------------------------------------------
// Testbench memory
// Sparse line store answering line reads and writes, with stalls
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module mem_model
  import cache_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      stall,         // Holds off both handshakes
  input  mem_req_t  mem_req,
  input  logic      mem_req_val,
  output logic      mem_req_rdy,
  output mem_resp_t mem_resp,
  output logic      mem_resp_val,
  input  logic      mem_resp_rdy
);

  line_t store [logic [addr_w-1:0]];  // Written lines only
  logic  pending = 1'b0;

  // Unwritten words read as their own address with a fixed pattern
  function automatic line_t read_line(logic [addr_w-1:0] addr);
    line_t             line;
    logic [addr_w-1:0] word_addr;
    if (store.exists(addr)) begin
      line = store[addr];
    end else begin
      for (int i = 0; i < words_per_line; i++) begin
        word_addr = addr + addr_w'(4 * i);
        line[i*word_w +: word_w] = word_addr ^ 32'h5a5a_0000;
      end
    end
    return line;
  endfunction

  assign mem_req_rdy  = !pending && !stall;
  assign mem_resp_val = pending && !stall;

  always @(posedge clk) begin
    if (reset) begin
      pending  <= 1'b0;
      mem_resp <= '0;
    end else if (mem_req_val && mem_req_rdy) begin
      pending     <= 1'b1;
      mem_resp.op <= mem_req.op;
      if (mem_req.op == mem_write) begin
        store[mem_req.addr] = mem_req.data;  // Whole line replaced
        mem_resp.data <= '0;
      end else begin
        mem_resp.data <= read_line(mem_req.addr);
      end
    end else if (mem_resp_val && mem_resp_rdy) begin
      pending <= 1'b0;
    end
  end

endmodule

// ==== src/blocking_cache.sv ====
//--------------------------------------------------------------------------
// Blocking cache top
// Two-way set-associative write-back cache, one request at a time
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module blocking_cache
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  cache_req_t  cache_req,
  input  logic        cache_req_val,
  output logic        cache_req_rdy,
  output cache_resp_t cache_resp,
  output logic        cache_resp_val,
  input  logic        cache_resp_rdy,
  output mem_req_t    mem_req,
  output logic        mem_req_val,
  input  logic        mem_req_rdy,
  input  mem_resp_t   mem_resp,
  input  logic        mem_resp_val,
  output logic        mem_resp_rdy
);

  ctrl_t        ctrl;
  meta_status_t status;
  logic         victim_way;
  req_type_e    req_type;
  index_t       index;
  tag_t         req_tag;
  tag_t         tag0;
  tag_t         tag1;

  cache_ctrl_fsm ctrl_fsm (
    .clk            (clk),
    .reset          (reset),
    .cache_req_val  (cache_req_val),
    .cache_req_rdy  (cache_req_rdy),
    .cache_resp_val (cache_resp_val),
    .cache_resp_rdy (cache_resp_rdy),
    .mem_req_val    (mem_req_val),
    .mem_req_rdy    (mem_req_rdy),
    .mem_resp_val   (mem_resp_val),
    .mem_resp_rdy   (mem_resp_rdy),
    .req_type       (req_type),
    .status         (status),
    .ctrl           (ctrl)
  );

  cache_meta meta (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl),
    .index      (index),
    .req_tag    (req_tag),
    .tag0       (tag0),
    .tag1       (tag1),
    .status     (status),
    .victim_way (victim_way)
  );

  cache_datapath datapath (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl),
    .cache_req  (cache_req),
    .cache_resp (cache_resp),
    .mem_req    (mem_req),
    .mem_resp   (mem_resp),
    .hit        (status.hit),
    .hit_way    (status.hit_way),
    .victim_way (victim_way),
    .req_type   (req_type),
    .index      (index),
    .req_tag    (req_tag),
    .tag0       (tag0),
    .tag1       (tag1)
  );

endmodule

// ==== src/cache_datapath.sv ====
//--------------------------------------------------------------------------
// Cache datapath
// Request and line registers, tag and data ways, word merge and select
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module cache_datapath
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  ctrl_t       ctrl,
  input  cache_req_t  cache_req,
  output cache_resp_t cache_resp,
  output mem_req_t    mem_req,
  input  mem_resp_t   mem_resp,
  input  logic        hit,
  input  logic        hit_way,
  input  logic        victim_way,
  output req_type_e   req_type,
  output index_t      index,
  output tag_t        req_tag,
  output tag_t        tag0,
  output tag_t        tag1
);

  cache_req_t        req_q;
  line_t             refill_q;
  line_t             evict_line_q;
  logic [addr_w-1:0] evict_addr_q;
  logic              hit_q;

  logic [word_sel_w-1:0] word_off;
  logic                  wr_way;
  line_t                 line0;
  line_t                 line1;
  line_t                 merged_line;
  line_t                 line_wdata;
  line_t                 hit_line;
  tag_t                  victim_tag;

  assign req_type = req_q.op;
  assign index    = req_q.addr[offset_w +: index_w];
  assign req_tag  = req_q.addr[addr_w-1 -: tag_w];
  assign word_off = req_q.addr[offset_w-1 -: word_sel_w];

  //--------------------------------------------------------------------------
  // Registers
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ctrl.req_en) req_q <= cache_req;
    if (ctrl.refill_en) refill_q <= mem_resp.data;
    if (ctrl.evict_en) begin
      evict_line_q <= victim_way ? line1 : line0;
      evict_addr_q <= {victim_tag, index, {offset_w{1'b0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hit_q <= 1'b0;
    end else if (ctrl.resp_en) begin
      hit_q <= hit;
    end
  end

  //--------------------------------------------------------------------------
  // Way arrays and write data
  //--------------------------------------------------------------------------

  assign victim_tag = victim_way ? tag1 : tag0;
  assign wr_way     = ctrl.tag_wen ? victim_way : hit_way;

  always_comb begin
    merged_line = wr_way ? line1 : line0;
    merged_line[word_off*word_w +: word_w] = req_q.data;
  end

  assign line_wdata = ctrl.line_from_mem ? refill_q : merged_line;

  way_array #(.payload_t(tag_t)) tag_way0 (
    .clk   (clk),
    .wen   (ctrl.tag_wen && !wr_way),
    .index (index),
    .wdata (req_tag),
    .rdata (tag0)
  );

  way_array #(.payload_t(tag_t)) tag_way1 (
    .clk   (clk),
    .wen   (ctrl.tag_wen && wr_way),
    .index (index),
    .wdata (req_tag),
    .rdata (tag1)
  );

  way_array #(.payload_t(line_t)) data_way0 (
    .clk   (clk),
    .wen   (ctrl.data_wen && !wr_way),
    .index (index),
    .wdata (line_wdata),
    .rdata (line0)
  );

  way_array #(.payload_t(line_t)) data_way1 (
    .clk   (clk),
    .wen   (ctrl.data_wen && wr_way),
    .index (index),
    .wdata (line_wdata),
    .rdata (line1)
  );

  //--------------------------------------------------------------------------
  // Response and memory request
  //--------------------------------------------------------------------------

  assign hit_line = hit_way ? line1 : line0;

  always_comb begin
    cache_resp.op   = req_q.op;
    cache_resp.hit  = hit_q;
    cache_resp.data = '0;    // Writes and inits return zero
    if (req_q.op == req_read) begin
      cache_resp.data = hit_line[word_off*word_w +: word_w];
    end
  end

  always_comb begin
    if (ctrl.evict_sel) begin
      mem_req.op   = mem_write;
      mem_req.addr = evict_addr_q;
      mem_req.data = evict_line_q;
    end else begin
      mem_req.op   = mem_read;
      mem_req.addr = {req_tag, index, {offset_w{1'b0}}};
      mem_req.data = '0;
    end
  end

endmodule

// ==== src/cache_ctrl_fsm.sv ====
//--------------------------------------------------------------------------
// Cache controller FSM
// Sequences tag check, access, eviction, refill and the response
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module cache_ctrl_fsm
  import cache_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         cache_req_val,
  output logic         cache_req_rdy,
  output logic         cache_resp_val,
  input  logic         cache_resp_rdy,
  output logic         mem_req_val,
  input  logic         mem_req_rdy,
  input  logic         mem_resp_val,
  output logic         mem_resp_rdy,
  input  req_type_e    req_type,
  input  meta_status_t status,
  output ctrl_t        ctrl
);

  state_e state;
  state_e state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  //--------------------------------------------------------------------------
  // Next state
  //--------------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (cache_req_val) state_next = st_tag_check;
      st_tag_check: begin
        if (req_type == req_init) begin
          state_next = st_init;
        end else if (status.hit && req_type == req_write) begin
          state_next = st_write;
        end else if (status.hit) begin
          state_next = st_read;
        end else if (status.victim_dirty) begin
          state_next = st_evict_prep;
        end else begin
          state_next = st_refill_req;
        end
      end
      st_init, st_read, st_write: state_next = st_wait;
      st_evict_prep:  state_next = st_evict_req;
      st_evict_req:   if (mem_req_rdy) state_next = st_evict_wait;
      st_evict_wait:  if (mem_resp_val) state_next = st_refill_req;  // Write ack
      st_refill_req:  if (mem_req_rdy) state_next = st_refill_wait;
      st_refill_wait: if (mem_resp_val) state_next = st_refill_update;
      st_refill_update: begin
        state_next = (req_type == req_write) ? st_write : st_read;
      end
      st_wait: if (cache_resp_rdy) state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  //--------------------------------------------------------------------------
  // Control table
  //--------------------------------------------------------------------------

  always_comb begin
    cache_req_rdy  = 1'b0;
    cache_resp_val = 1'b0;
    mem_req_val    = 1'b0;
    mem_resp_rdy   = 1'b0;
    ctrl           = '0;
    case (state)
      st_idle: begin
        cache_req_rdy = 1'b1;
        ctrl.req_en   = 1'b1;
      end
      st_tag_check: ctrl.resp_en = 1'b1;   // Latch hit for the response
      st_init: begin
        ctrl.init_way0      = 1'b1;
        ctrl.tag_wen        = 1'b1;
        ctrl.data_wen       = 1'b1;
        ctrl.meta_valid_wen = 1'b1;
        ctrl.meta_dirty_wen = 1'b1;
        ctrl.dirty_in       = 1'b1;  // Memory never saw this word
        ctrl.lru_en         = 1'b1;
      end
      st_read: ctrl.lru_en = 1'b1;
      st_write: begin
        ctrl.data_wen       = 1'b1;
        ctrl.meta_dirty_wen = 1'b1;
        ctrl.dirty_in       = 1'b1;
        ctrl.lru_en         = 1'b1;
      end
      st_evict_prep: ctrl.evict_en = 1'b1;
      st_evict_req: begin
        mem_req_val    = 1'b1;
        ctrl.evict_sel = 1'b1;
      end
      st_evict_wait: begin
        mem_resp_rdy   = 1'b1;
        ctrl.evict_sel = 1'b1;
      end
      st_refill_req: mem_req_val = 1'b1;
      st_refill_wait: begin
        mem_resp_rdy   = 1'b1;
        ctrl.refill_en = 1'b1;
      end
      st_refill_update: begin
        ctrl.tag_wen        = 1'b1;
        ctrl.data_wen       = 1'b1;
        ctrl.line_from_mem  = 1'b1;
        ctrl.meta_valid_wen = 1'b1;
        ctrl.meta_dirty_wen = 1'b1;  // Clean after refill
      end
      st_wait: cache_resp_val = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

// ==== src/cache_meta.sv ====
//--------------------------------------------------------------------------
// Cache metadata
// Valid, dirty and LRU bits per set with hit detection and victim choice
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module cache_meta
  import cache_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  ctrl_t        ctrl,
  input  index_t       index,
  input  tag_t         req_tag,
  input  tag_t         tag0,
  input  tag_t         tag1,
  output meta_status_t status,
  output logic         victim_way
);

  logic [1:0][num_sets-1:0] valid;   // [way][set]
  logic [1:0][num_sets-1:0] dirty;
  logic [num_sets-1:0]      lru;     // Way to replace next

  logic match0;
  logic match1;
  logic wr_way;

  assign match0 = valid[0][index] && (tag0 == req_tag);
  assign match1 = valid[1][index] && (tag1 == req_tag);

  // Init always lands in way 0
  assign victim_way = ctrl.init_way0 ? 1'b0 : lru[index];

  always_comb begin
    status.hit          = match0 || match1;
    status.hit_way      = match1;
    status.victim_dirty = valid[victim_way][index] && dirty[victim_way][index];
  end

  // Installs write the victim's bits, accesses the hit way's
  assign wr_way = ctrl.tag_wen ? victim_way : match1;

  //--------------------------------------------------------------------------
  // State update
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
      lru   <= '0;
    end else begin
      if (ctrl.meta_valid_wen) begin
        valid[wr_way][index] <= 1'b1;
      end
      if (ctrl.meta_dirty_wen) begin
        dirty[wr_way][index] <= ctrl.dirty_in;
      end
      if (ctrl.lru_en) begin
        lru[index] <= ~wr_way;  // Other way becomes the victim
      end
    end
  end

endmodule

// ==== src/way_array.sv ====
//--------------------------------------------------------------------------
// Way storage array
// One entry per set, clocked write and combinational read
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module way_array
  import cache_pkg::*;
#(
  parameter type payload_t = tag_t
) (
  input  logic     clk,
  input  logic     wen,
  input  index_t   index,
  input  payload_t wdata,
  output payload_t rdata
);

  payload_t mem [num_sets];

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[index] <= wdata;
    end
  end

  assign rdata = mem[index];  // Read of the current set

endmodule

// ==== src/cache_pkg.sv ====
//--------------------------------------------------------------------------
// Blocking cache package
// Geometry, request and memory codes, FSM states and the shared structs
//--------------------------------------------------------------------------

package cache_pkg;

  // Geometry of a 256 byte, 2-way cache with 16 byte lines
  localparam int addr_w         = 32;
  localparam int word_w         = 32;
  localparam int line_w         = 128;
  localparam int offset_w       = 4;
  localparam int index_w        = 3;
  localparam int num_sets       = 2 ** index_w;
  localparam int tag_w          = addr_w - index_w - offset_w;  // 25 bits
  localparam int words_per_line = line_w / word_w;
  localparam int word_sel_w     = $clog2(words_per_line);

  typedef logic [tag_w-1:0]   tag_t;
  typedef logic [index_w-1:0] index_t;
  typedef logic [line_w-1:0]  line_t;
  typedef logic [word_w-1:0]  word_t;

  typedef enum logic [2:0] {
    req_read  = 3'd0,
    req_write = 3'd1,
    req_init  = 3'd2
  } req_type_e;

  typedef enum logic [2:0] {
    mem_read  = 3'd0,
    mem_write = 3'd1
  } mem_type_e;

  typedef enum logic [3:0] {
    st_idle,
    st_tag_check,
    st_init,
    st_read,
    st_write,
    st_evict_prep,
    st_evict_req,
    st_evict_wait,
    st_refill_req,
    st_refill_wait,
    st_refill_update,
    st_wait
  } state_e;

  //--------------------------------------------------------------------------
  // Messages on the cache and memory sides
  //--------------------------------------------------------------------------

  typedef struct packed {
    req_type_e         op;
    logic [addr_w-1:0] addr;
    word_t             data;
  } cache_req_t;

  typedef struct packed {
    req_type_e op;
    logic      hit;
    word_t     data;
  } cache_resp_t;

  typedef struct packed {
    mem_type_e         op;
    logic [addr_w-1:0] addr;    // Line aligned
    line_t             data;
  } mem_req_t;

  typedef struct packed {
    mem_type_e op;
    line_t     data;
  } mem_resp_t;

  // Steering from the FSM to the datapath and metadata
  typedef struct packed {
    logic req_en;
    logic refill_en;
    logic tag_wen;
    logic data_wen;
    logic line_from_mem;   // Refill line instead of merged word
    logic evict_en;
    logic evict_sel;       // Memory request carries the victim
    logic meta_valid_wen;
    logic meta_dirty_wen;
    logic dirty_in;
    logic lru_en;
    logic init_way0;
    logic resp_en;
  } ctrl_t;

  typedef struct packed {
    logic hit;
    logic hit_way;
    logic victim_dirty;
  } meta_status_t;

endpackage
